/* verilog/fetch_pkg.sv */
// Fetch front end package with response and decode types, tag codes, NOP and vectors
package fetch_pkg;

	////////////////////
	// Bus response tags
	////////////////////

	// Tag returned with an instruction bus response
	// Only meaningful together with an error strobe
	typedef enum logic [3:0] {
		TAG_NONE       = 4'h0,
		TAG_BUS_ERR    = 4'hB,
		TAG_PAGE_FAULT = 4'hC,
		TAG_TLB_MISS   = 4'hD
	} ibus_tag_e;

	////////////////////
	// Fetch exceptions
	////////////////////

	// Exception raised by the fetch stage toward decode and PC generator
	typedef enum logic [1:0] {
		EXC_NONE,
		EXC_TLB_MISS,
		EXC_PAGE_FAULT,
		EXC_BUS_ERR
	} fetch_exc_e;

	// Bus response as seen by the fetch stage
	// adr comes from the request address register, always word aligned
	typedef struct packed {
		logic [31:0] dat;
		logic [31:0] adr;
		ibus_tag_e   tag;
		logic        ack;
		logic        err;
	} fetch_rsp_t;

	// Instruction slot handed to decode
	typedef struct packed {
		logic [31:0] insn;
		logic [31:0] pc;
		fetch_exc_e  exc;
	} fetch_out_t;

	////////////////////
	// Constants
	////////////////////

	// l.nop encoding, opcode 6'b000101 with a fixed immediate
	localparam logic [31:0] NOP_INSN = 32'h1541_0000;

	// Exception vectors for fetch errors
	localparam logic [31:0] VEC_BUS_ERR    = 32'h0000_0200;
	localparam logic [31:0] VEC_PAGE_FAULT = 32'h0000_0400;
	localparam logic [31:0] VEC_TLB_MISS   = 32'h0000_0A00;

endpackage

/* verilog/fetch_pc_gen.sv */
// Fetch PC generator with sequential advance, branch redirect and exception vector redirect
`timescale 1ns/1ps

module fetch_pc_gen #(
	parameter logic [31:0] RESET_PC = 32'h0000_0100
) (
	input  logic                  clk,
	input  logic                  rst_i,
	// Strobe for an instruction handed to decode
	input  logic                  if_valid_i,
	input  fetch_pkg::fetch_out_t fout_i,
	// Branch redirect from the core
	input  logic                  branch_i,
	input  logic [31:0]           branch_pc_i,
	// Current fetch address
	output logic [31:0]           pc_o
);
	import fetch_pkg::*;

	logic [31:0] pc_q;
	logic [31:0] pc_d;

	// Vector lookup for a fetch exception
	// EXC_NONE never reaches here, falls back to the bus error vector
	function automatic logic [31:0] exc_vector(input fetch_exc_e exc);
		logic [31:0] vec;
		case (exc)
			EXC_TLB_MISS:   vec = VEC_TLB_MISS;
			EXC_PAGE_FAULT: vec = VEC_PAGE_FAULT;
			default:        vec = VEC_BUS_ERR;
		endcase
		return vec;
	endfunction

	////////////////////
	// Next PC select
	////////////////////

	// Priority order
	// 1. branch target, taken in any cycle
	// 2. exception vector of the delivered slot
	// 3. delivered address plus one word
	always_comb begin
		pc_d = pc_q;
		if (branch_i) begin
			pc_d = branch_pc_i;
		end else if (if_valid_i) begin
			if (fout_i.exc != EXC_NONE) begin
				pc_d = exc_vector(fout_i.exc);
			end else begin
				// Step from the delivered address, matches pc_q in normal flow
				pc_d = fout_i.pc + 32'd4;
			end
		end
	end

	////////////////////
	// PC register
	////////////////////

	// Holds while nothing is delivered, so freeze stalls it too
	always_ff @(posedge clk) begin
		if (rst_i) begin
			pc_q <= RESET_PC;
		end else begin
			pc_q <= pc_d;
		end
	end

	assign pc_o = pc_q;

endmodule

/* verilog/fetch_bus_if.sv */
// Instruction bus master issuing one fetch at a time and dropping flushed responses
`timescale 1ns/1ps

module fetch_bus_if (
	input  logic                  clk,
	input  logic                  rst_i,
	// Fetch address from the PC generator
	input  logic [31:0]           pc_i,
	// Pipeline control
	input  logic                  flush_i,
	input  logic                  freeze_i,
	// Fetch stage holds a saved response
	input  logic                  saved_i,
	// Instruction bus
	output logic                  ibus_req_o,
	output logic [31:0]           ibus_adr_o,
	input  logic                  ibus_ack_i,
	input  logic                  ibus_err_i,
	input  logic [31:0]           ibus_dat_i,
	input  fetch_pkg::ibus_tag_e  ibus_tag_i,
	// Response toward the fetch stage
	output fetch_pkg::fetch_rsp_t rsp_o
);
	import fetch_pkg::*;

	// IDLE  no request on the bus
	// WAIT  request out, response goes to the stage
	// DROP  request out, response belongs to a flushed fetch
	typedef enum logic [1:0] {
		IDLE,
		WAIT,
		DROP
	} state_e;

	state_e      state_q;
	logic [31:0] adr_q;
	logic        bus_done;
	logic        start;
	logic        take_rsp;

	// Bus answered this cycle, either way
	assign bus_done = ibus_ack_i | ibus_err_i;

	// New fetch only with a settled PC
	// Flush means the PC changes at this edge, so wait one cycle
	assign start = (state_q == IDLE) & ~freeze_i & ~saved_i & ~flush_i;

	// Only a live request in WAIT passes its response on
	// A flush in the same cycle kills it as well
	assign take_rsp = (state_q == WAIT) & ~flush_i;

	////////////////////
	// Request FSM
	////////////////////

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= IDLE;
		end else begin
			case (state_q)
				IDLE: begin
					if (start) begin
						state_q <= WAIT;
					end
				end
				WAIT: begin
					if (bus_done) begin
						state_q <= IDLE;
					end else if (flush_i) begin
						// Stale word still in flight
						state_q <= DROP;
					end
				end
				DROP: begin
					// Swallow the answer, then fetch from the new PC
					if (bus_done) begin
						state_q <= IDLE;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// Word aligned request address, held for the whole transfer
	always_ff @(posedge clk) begin
		if (start) begin
			adr_q <= {pc_i[31:2], 2'b00};
		end
	end

	// Level request, low again in the cycle after ack or err
	assign ibus_req_o = (state_q != IDLE);
	assign ibus_adr_o = adr_q;

	////////////////////
	// Response path
	////////////////////

	always_comb begin
		rsp_o.dat = ibus_dat_i;
		rsp_o.adr = adr_q;
		rsp_o.tag = ibus_tag_i;
		// Strobes masked while dropping
		rsp_o.ack = ibus_ack_i & take_rsp;
		rsp_o.err = ibus_err_i & take_rsp;
	end

endmodule

/* verilog/fetch_stage.sv */
// Fetch stage that saves frozen responses, inserts NOPs and classifies fetch errors
`timescale 1ns/1ps

module fetch_stage (
	input  logic                  clk,
	input  logic                  rst_i,
	// Response from the bus interface
	input  fetch_pkg::fetch_rsp_t rsp_i,
	// Pipeline control from decode
	input  logic                  freeze_i,
	input  logic                  flush_i,
	input  logic                  no_more_dslot_i,
	input  logic                  rfe_i,
	// Slot toward decode
	output fetch_pkg::fetch_out_t fout_o,
	output logic                  if_valid_o,
	// Saved response pending
	output logic                  saved_o
);
	import fetch_pkg::*;

	logic        rsp_hit;
	logic        save_insn;
	fetch_exc_e  rsp_exc;
	logic        saved_q;
	fetch_exc_e  saved_exc_q;
	logic [31:0] saved_insn_q;
	logic [31:0] saved_pc_q;
	logic        bypass_q;
	logic        bypass;
	logic        nop_sel;

	// Error tag to fetch exception
	// Untagged or unknown errors count as bus errors
	function automatic fetch_exc_e tag_to_exc(input ibus_tag_e tag);
		fetch_exc_e exc;
		case (tag)
			TAG_TLB_MISS:   exc = EXC_TLB_MISS;
			TAG_PAGE_FAULT: exc = EXC_PAGE_FAULT;
			default:        exc = EXC_BUS_ERR;
		endcase
		return exc;
	endfunction

	// Response present this cycle
	assign rsp_hit = rsp_i.ack | rsp_i.err;

	always_comb begin
		rsp_exc = EXC_NONE;
		if (rsp_i.err) begin
			rsp_exc = tag_to_exc(rsp_i.tag);
		end
	end

	// Capture only the first response that meets a freeze
	assign save_insn = rsp_hit & freeze_i & ~saved_q;

	////////////////////
	// Saved response
	////////////////////

	// Flag and exception
	always_ff @(posedge clk) begin
		if (rst_i) begin
			saved_q     <= 1'b0;
			saved_exc_q <= EXC_NONE;
		end else if (flush_i) begin
			saved_q     <= 1'b0;
			saved_exc_q <= EXC_NONE;
		end else if (save_insn) begin
			saved_q     <= 1'b1;
			saved_exc_q <= rsp_exc;
		end else if (!freeze_i) begin
			// Delivered in this unfrozen cycle
			saved_q     <= 1'b0;
			saved_exc_q <= EXC_NONE;
		end
	end

	// Word and address, only read while saved_q is set
	always_ff @(posedge clk) begin
		if (save_insn) begin
			saved_insn_q <= rsp_i.err ? NOP_INSN : rsp_i.dat;
			saved_pc_q   <= rsp_i.adr;
		end
	end

	////////////////////
	// Flush bypass
	////////////////////

	// Set by flush, cleared by the first fresh response
	always_ff @(posedge clk) begin
		if (rst_i) begin
			bypass_q <= 1'b0;
		end else if (flush_i) begin
			bypass_q <= 1'b1;
		end else if (rsp_hit) begin
			bypass_q <= 1'b0;
		end
	end

	// The fresh word itself is not covered
	assign bypass  = flush_i | (bypass_q & ~rsp_hit);
	assign nop_sel = bypass | no_more_dslot_i | rfe_i;

	////////////////////
	// Decode slot
	////////////////////

	always_comb begin
		// Instruction, saved word first, then bus word, NOP on error
		if (nop_sel) begin
			fout_o.insn = NOP_INSN;
		end else if (saved_q) begin
			fout_o.insn = saved_insn_q;
		end else if (rsp_i.ack) begin
			fout_o.insn = rsp_i.dat;
		end else begin
			fout_o.insn = NOP_INSN;
		end

		fout_o.pc = saved_q ? saved_pc_q : rsp_i.adr;

		// No exception out of a killed delay slot or an rfe slot
		if (no_more_dslot_i | rfe_i) begin
			fout_o.exc = EXC_NONE;
		end else if (saved_q) begin
			fout_o.exc = saved_exc_q;
		end else begin
			fout_o.exc = rsp_exc;
		end
	end

	// A flushed slot carries no instruction
	assign if_valid_o = (rsp_hit | saved_q) & ~freeze_i & ~flush_i;
	assign saved_o    = saved_q;

endmodule

/* verilog/fetch_top.sv */
// Fetch front end top joining PC generator, instruction bus master and fetch stage
`timescale 1ns/1ps

module fetch_top #(
	parameter logic [31:0] RESET_PC = 32'h0000_0100
) (
	input  logic                 clk,
	input  logic                 rst_i,
	// Pipeline control from the core
	input  logic                 freeze_i,
	input  logic                 flush_i,
	input  logic                 branch_i,
	input  logic [31:0]          branch_pc_i,
	input  logic                 no_more_dslot_i,
	input  logic                 rfe_i,
	// Instruction bus
	output logic                 ibus_req_o,
	output logic [31:0]          ibus_adr_o,
	input  logic                 ibus_ack_i,
	input  logic                 ibus_err_i,
	input  logic [31:0]          ibus_dat_i,
	input  fetch_pkg::ibus_tag_e ibus_tag_i,
	// Decode side
	output logic [31:0]          if_insn_o,
	output logic [31:0]          if_pc_o,
	output fetch_pkg::fetch_exc_e if_exc_o,
	output logic                 if_valid_o
);
	import fetch_pkg::*;

	logic [31:0] pc;
	fetch_rsp_t  rsp;
	fetch_out_t  fout;
	logic        saved;
	logic        if_valid;

	// Fetch PC, advanced by delivered slots and branches
	fetch_pc_gen #(
		.RESET_PC(RESET_PC)
	) pc_gen_i (
		.clk        (clk),
		.rst_i      (rst_i),
		.if_valid_i (if_valid),
		.fout_i     (fout),
		.branch_i   (branch_i),
		.branch_pc_i(branch_pc_i),
		.pc_o       (pc)
	);

	// Single outstanding bus transfer
	fetch_bus_if bus_if_i (
		.clk       (clk),
		.rst_i     (rst_i),
		.pc_i      (pc),
		.flush_i   (flush_i),
		.freeze_i  (freeze_i),
		.saved_i   (saved),
		.ibus_req_o(ibus_req_o),
		.ibus_adr_o(ibus_adr_o),
		.ibus_ack_i(ibus_ack_i),
		.ibus_err_i(ibus_err_i),
		.ibus_dat_i(ibus_dat_i),
		.ibus_tag_i(ibus_tag_i),
		.rsp_o     (rsp)
	);

	// Response hold, NOP insertion and error classification
	fetch_stage stage_i (
		.clk            (clk),
		.rst_i          (rst_i),
		.rsp_i          (rsp),
		.freeze_i       (freeze_i),
		.flush_i        (flush_i),
		.no_more_dslot_i(no_more_dslot_i),
		.rfe_i          (rfe_i),
		.fout_o         (fout),
		.if_valid_o     (if_valid),
		.saved_o        (saved)
	);

	// Slot fields out to decode
	assign if_insn_o  = fout.insn;
	assign if_pc_o    = fout.pc;
	assign if_exc_o   = fout.exc;
	assign if_valid_o = if_valid;

endmodule

/* tb/fetch_tb.sv */
// Testbench for the fetch front end with bus responder, reference model and checks
`timescale 1ns/1ps

module fetch_tb;
	import fetch_pkg::*;

	localparam logic [31:0] RESET_PC = 32'h0000_0100;
	localparam logic [31:0] SEED     = 32'h1f9c_e9f2;
	// Slot budget over all tests, slack for freezes and redirects included
	localparam int          TEST_CYCLES = 300;

	logic        clk;
	logic        rst_i;
	logic        freeze_i;
	logic        flush_i;
	logic        branch_i;
	logic [31:0] branch_pc_i;
	logic        no_more_dslot_i;
	logic        rfe_i;
	logic        ibus_req_o;
	logic [31:0] ibus_adr_o;
	logic        ibus_ack_i;
	logic        ibus_err_i;
	logic [31:0] ibus_dat_i;
	ibus_tag_e   ibus_tag_i;
	logic [31:0] if_insn_o;
	logic [31:0] if_pc_o;
	fetch_exc_e  if_exc_o;
	logic        if_valid_o;
	logic [31:0] rng_stim;
	logic [31:0] exp_pc;
	int          n_deliv   = 0;
	int          n_checks  = 0;
	int          err_count = 0;
	int          exc_seen  = 0;
	int          tests_bad = 0;

	fetch_top #(.RESET_PC(RESET_PC)) dut_i (.*);

	////////////////////
	// Reference model
	////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Instruction word stored at an address
	function automatic logic [31:0] hash_word(input logic [31:0] adr);
		return lcg_next(adr ^ SEED);
	endfunction

	// Error windows, two words each
	function automatic ibus_tag_e err_tag_of(input logic [31:0] adr);
		if (adr >= 32'h3000 && adr < 32'h3008) return TAG_TLB_MISS;
		if (adr >= 32'h4000 && adr < 32'h4008) return TAG_PAGE_FAULT;
		if (adr >= 32'h5000 && adr < 32'h5008) return TAG_BUS_ERR;
		return TAG_NONE;
	endfunction

	// Expected slot for a fetch at pc, kill covers no_more_dslot and rfe
	function automatic fetch_out_t ref_fetch(input logic [31:0] pc, input logic kill);
		fetch_out_t r;
		ibus_tag_e  tag;
		tag    = err_tag_of(pc);
		r.pc   = pc;
		r.insn = NOP_INSN;
		r.exc  = EXC_NONE;
		if (!kill) begin
			case (tag)
				TAG_TLB_MISS:   r.exc = EXC_TLB_MISS;
				TAG_PAGE_FAULT: r.exc = EXC_PAGE_FAULT;
				TAG_BUS_ERR:    r.exc = EXC_BUS_ERR;
				default:        r.insn = hash_word(pc);
			endcase
		end
		return r;
	endfunction

	// Fetch address after a delivered slot
	function automatic logic [31:0] next_pc_of(input fetch_out_t r);
		case (r.exc)
			EXC_TLB_MISS:   return VEC_TLB_MISS;
			EXC_PAGE_FAULT: return VEC_PAGE_FAULT;
			EXC_BUS_ERR:    return VEC_BUS_ERR;
			default:        return r.pc + 32'd4;
		endcase
	endfunction

	////////////////////
	// Checks
	////////////////////

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			err_count++;
		end
	endtask

	task automatic check_exc(input string name, input fetch_exc_e got, input fetch_exc_e exp);
		n_checks++;
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			err_count++;
		end
	endtask

	task automatic report_test(input int num, input string name, input int errs_before,
			input int slots_before);
		int errs;
		errs = err_count - errs_before;
		$display("Test %0d %s: %0d slots, %0d errors", num, name, n_deliv - slots_before, errs);
		if (errs != 0) begin
			tests_bad++;
		end
	endtask

	////////////////////
	// Stimulus helpers
	////////////////////

	// Called right after a falling edge, flush comes with every taken branch
	task automatic branch_to(input logic [31:0] target);
		branch_i    = 1'b1;
		flush_i     = 1'b1;
		branch_pc_i = target;
		@(negedge clk);
		branch_i = 1'b0;
		flush_i  = 1'b0;
	endtask

	// Wait for n more delivered slots, optionally with random freeze
	task automatic wait_slots(input int n, input logic use_freeze);
		int target;
		target = n_deliv + n;
		while (n_deliv < target) begin
			@(negedge clk);
			if (use_freeze) begin
				rng_stim = lcg_next(rng_stim);
				freeze_i = (rng_stim[31:30] == 2'd0);
			end
		end
		freeze_i = 1'b0;
	endtask

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// Instruction bus responder, 1 to 4 cycles of latency
	initial begin
		logic        busy;
		logic        done_q;
		logic [1:0]  cnt;
		logic [31:0] rng_bus;
		busy       = 1'b0;
		done_q     = 1'b0;
		cnt        = 2'd0;
		rng_bus    = SEED;
		ibus_ack_i = 1'b0;
		ibus_err_i = 1'b0;
		ibus_dat_i = 32'd0;
		ibus_tag_i = TAG_NONE;
		forever begin
			@(negedge clk);
			ibus_ack_i = 1'b0;
			ibus_err_i = 1'b0;
			ibus_tag_i = TAG_NONE;
			// Request is low again one cycle after the answer
			if (done_q) begin
				check_word("ibus_req_o", 32'(ibus_req_o), 32'd0);
			end
			done_q = 1'b0;
			if (ibus_req_o && !busy && !rst_i) begin
				// A new request goes out for the next fetch PC of the model
				check_word("ibus_adr_o", ibus_adr_o, exp_pc);
				rng_bus = lcg_next(rng_bus);
				cnt     = rng_bus[17:16];
				busy    = 1'b1;
			end
			if (busy && cnt == 2'd0) begin
				ibus_dat_i = hash_word(ibus_adr_o);
				ibus_tag_i = err_tag_of(ibus_adr_o);
				ibus_ack_i = (ibus_tag_i == TAG_NONE);
				ibus_err_i = (ibus_tag_i != TAG_NONE);
				busy       = 1'b0;
				done_q     = 1'b1;
			end else if (busy) begin
				cnt = cnt - 2'd1;
			end
		end
	end

	// Compare, sampled halfway between falling and rising edge
	initial begin
		fetch_out_t exp;
		exp_pc = RESET_PC;
		forever begin
			@(negedge clk);
			#10;
			if (rst_i) begin
				exp_pc = RESET_PC;
			end else if (branch_i) begin
				exp_pc = branch_pc_i;
			end else if (if_valid_o) begin
				exp = ref_fetch(exp_pc, no_more_dslot_i | rfe_i);
				check_word("if_insn_o", if_insn_o, exp.insn);
				check_word("if_pc_o", if_pc_o, exp.pc);
				check_exc("if_exc_o", if_exc_o, exp.exc);
				if (if_exc_o != EXC_NONE) exc_seen++;
				exp_pc = next_pc_of(exp);
				n_deliv++;
			end
		end
	end

	initial begin
		#(TEST_CYCLES * 5 * 40);
		$display("Timeout: tests did not finish within %0d ns", TEST_CYCLES * 5 * 40);
		$display("Something failed");
		$finish;
	end

	initial begin
		int errs_before;
		int slots_before;
		int exc_before;
		rst_i           = 1'b1;
		freeze_i        = 1'b0;
		flush_i         = 1'b0;
		branch_i        = 1'b0;
		branch_pc_i     = 32'd0;
		no_more_dslot_i = 1'b0;
		rfe_i           = 1'b0;
		rng_stim        = lcg_next(SEED);
		repeat (2) @(negedge clk);
		rst_i = 1'b0;

		errs_before  = err_count;
		slots_before = n_deliv;
		wait_slots(40, 1'b0);
		report_test(1, "sequential fetch", errs_before, slots_before);

		errs_before  = err_count;
		slots_before = n_deliv;
		wait_slots(40, 1'b1);
		report_test(2, "random freeze", errs_before, slots_before);

		// Redirect while a request is out, stale word must vanish
		errs_before  = err_count;
		slots_before = n_deliv;
		for (int i = 0; i < 8; i++) begin
			do @(negedge clk); while (!ibus_req_o);
			branch_to(32'h1000 + 32'(i) * 32'h80);
			wait_slots(4, 1'b0);
		end
		report_test(3, "branch with flush", errs_before, slots_before);

		// One window per tag, then a few words from its vector
		errs_before  = err_count;
		slots_before = n_deliv;
		exc_before   = exc_seen;
		branch_to(32'h2FF8);
		wait_slots(6, 1'b1);
		branch_to(32'h3FF8);
		wait_slots(6, 1'b1);
		branch_to(32'h4FF8);
		wait_slots(6, 1'b1);
		if (exc_seen - exc_before != 3) begin
			$display("Error: expected three fetch exceptions, saw %0d", exc_seen - exc_before);
			err_count++;
		end
		report_test(4, "error responses", errs_before, slots_before);

		// Killed slots over error windows
		errs_before     = err_count;
		slots_before    = n_deliv;
		no_more_dslot_i = 1'b1;
		branch_to(32'h2FF8);
		wait_slots(5, 1'b0);
		no_more_dslot_i = 1'b0;
		rfe_i           = 1'b1;
		branch_to(32'h4FF8);
		wait_slots(5, 1'b0);
		rfe_i = 1'b0;
		report_test(5, "no_more_dslot and rfe", errs_before, slots_before);

		$display("Summary: 5 tests, %0d with errors, %0d checks, %0d errors",
			tests_bad, n_checks, err_count);
		if (err_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

/* sim.f */
verilog/fetch_pkg.sv
verilog/fetch_pc_gen.sv
verilog/fetch_bus_if.sv
verilog/fetch_stage.sv
verilog/fetch_top.sv
tb/fetch_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the fetch front end testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps -f sim.f --top-module fetch_tb -o fetch_sim \
	&& ./obj_dir/fetch_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Something failed" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "Everything OK" sim.log || { echo "No pass line in log"; exit 1; }
echo "Simulation passed"
